// File: filelist.f
+incdir+hw
hw/net_addr_pkg.sv
hw/net_frame_pkg.sv
hw/tx_arbiter.sv
hw/tx_header_calc.sv
hw/header_prepend.sv
hw/net_tx_top.sv
tests/tb_net_tx.sv

// File: hw/header_prepend.sv
// generic header prepend stage
// shifts a header out msb first, then forwards the payload
// through a one-beat output register

`timescale 1ns/1ps
`default_nettype none

module header_prepend #(
  parameter type hdr_t = logic [15:0]
) (
  input  wire                            tx_clock,
  input  wire                            rst_n,
  input  wire hdr_t                      hdr,
  input  wire                            hdr_en,
  input  wire                            hdr_valid,
  output logic                           hdr_ready,
  input  wire net_frame_pkg::byte_beat_t in_beat,
  input  wire                            in_valid,
  output logic                           in_ready,
  output net_frame_pkg::byte_beat_t      out_beat,
  output logic                           out_valid,
  input  wire                            out_ready
);
  import net_frame_pkg::*;

  // header size taken from the type
  localparam int HDR_W     = $bits(hdr_t);
  localparam int HDR_BYTES = HDR_W / 8;
  localparam int CNT_W     = $clog2(HDR_BYTES + 1);

  logic [HDR_W-1:0] shift_q;
  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;
  logic             slot_free;
  logic             take_hdr;
  logic             load_hdr;
  logic             take_in;
  byte_beat_t       out_q;
  logic             out_valid_q;

  // ------------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------------
  // output slot empty or being drained this cycle
  assign slot_free = !out_valid_q || out_ready;
  // next meta once the last beat of this frame leaves
  assign hdr_ready = !busy_q && slot_free;
  assign take_hdr  = hdr_valid && hdr_ready;
  // header bytes go out before any payload
  assign load_hdr  = busy_q && slot_free && (cnt_q != '0);
  assign in_ready  = busy_q && slot_free && (cnt_q == '0);
  assign take_in   = in_valid && in_ready;

  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  // frame state and output valid
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (take_hdr) begin
        busy_q <= 1'b1;
        // enable clear skips straight to payload
        cnt_q  <= hdr_en ? CNT_W'(HDR_BYTES) : '0;
      end else if (load_hdr) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end else if (take_in && in_beat.last) begin
        busy_q <= 1'b0;
      end

      if (load_hdr || take_in) begin
        out_valid_q <= 1'b1;
      end else if (out_ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // header shifter and output data
  // ------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (take_hdr) begin
      shift_q <= hdr;
    end else if (load_hdr) begin
      shift_q <= shift_q << 8;
    end

    if (load_hdr) begin
      out_q.data <= shift_q[HDR_W-1 -: 8];
      out_q.last <= 1'b0;
    end else if (take_in) begin
      // payload passes unchanged
      out_q <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: hw/net_addr_pkg.sv
// address types for this station and for remote endpoints
// mac, ipv4, udp port and the structs built from them

`default_nettype none

package net_addr_pkg;

  // ------------------------------------------------------------------
  // scalar address types
  // ------------------------------------------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] udp_port_t;

  // ------------------------------------------------------------------
  // grouped addresses
  // ------------------------------------------------------------------
  // own addresses, static while running
  typedef struct packed {
    mac_addr_t  mac;
    ipv4_addr_t ip;
  } station_t;

  // far end of a frame, carried with each request
  typedef struct packed {
    mac_addr_t  mac;
    ipv4_addr_t ip;
    udp_port_t  port;
  } endpoint_t;

endpackage

`default_nettype wire

// File: hw/net_frame_pkg.sv
// frame level types for the transmit path
// byte stream beat, client request, protocol select
// and the udp, ipv4 and ethernet header layouts

`default_nettype none

package net_frame_pkg;

  // one byte of a stream, last marks frame end
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_beat_t;

  // which client owns the frame
  typedef enum logic {
    PROTO_UDP  = 1'b0,
    PROTO_ICMP = 1'b1
  } proto_e;

  // frame request, destination travels with it
  typedef struct packed {
    proto_e                  proto;
    logic [15:0]             payload_len;
    net_addr_pkg::endpoint_t dst;
  } tx_req_t;

  // ------------------------------------------------------------------
  // headers, first field is sent first, msb first
  // ------------------------------------------------------------------
  typedef struct packed {
    net_addr_pkg::udp_port_t src_port;
    net_addr_pkg::udp_port_t dst_port;
    logic [15:0]             length;
    logic [15:0]             checksum;
  } udp_hdr_t;

  // twenty bytes, no options
  typedef struct packed {
    logic [7:0]               ver_ihl;
    logic [7:0]               tos;
    logic [15:0]              total_len;
    logic [15:0]              ident;
    logic [15:0]              flags_frag;
    logic [7:0]               ttl;
    logic [7:0]               proto;
    logic [15:0]              checksum;
    net_addr_pkg::ipv4_addr_t src_ip;
    net_addr_pkg::ipv4_addr_t dst_ip;
  } ipv4_hdr_t;

  typedef struct packed {
    net_addr_pkg::mac_addr_t dst_mac;
    net_addr_pkg::mac_addr_t src_mac;
    logic [15:0]             ethertype;
  } eth_hdr_t;

endpackage

`default_nettype wire

// File: hw/net_settings.svh
// constant header field values for the transmit framing path
// ethertype, ipv4 version/ihl, ttl, protocol numbers
// and the fixed local udp port

`ifndef NET_SETTINGS_SVH
`define NET_SETTINGS_SVH

// ethernet type field for ipv4 payload
`define NET_ETHERTYPE_IPV4 16'h0800

// version 4, five 32-bit header words
`define NET_IP_VER_IHL 8'h45

// hop limit on every sent datagram
`define NET_IP_TTL 8'd128

// ip protocol numbers
`define NET_IP_PROTO_UDP 8'd17
`define NET_IP_PROTO_ICMP 8'd1

// source port of all udp frames
`define NET_LOCAL_UDP_PORT 16'd1024

`endif

// File: hw/net_tx_top.sv
// transmit framing top level
// arbiter, header builder and udp, ip and ethernet prepend stages

`timescale 1ns/1ps
`default_nettype none

module net_tx_top (
  input  wire                            tx_clock,
  input  wire                            rst_n,
  input  wire net_addr_pkg::station_t    station,
  input  wire net_frame_pkg::tx_req_t    udp_req,
  input  wire                            udp_req_valid,
  output logic                           udp_req_ready,
  input  wire net_frame_pkg::tx_req_t    icmp_req,
  input  wire                            icmp_req_valid,
  output logic                           icmp_req_ready,
  input  wire net_frame_pkg::byte_beat_t udp_payload,
  input  wire                            udp_payload_valid,
  output logic                           udp_payload_ready,
  input  wire net_frame_pkg::byte_beat_t icmp_payload,
  input  wire                            icmp_payload_valid,
  output logic                           icmp_payload_ready,
  output net_frame_pkg::byte_beat_t      tx_out,
  output logic                           tx_out_valid,
  input  wire                            tx_out_ready
);
  import net_frame_pkg::*;

  // ------------------------------------------------------------------
  // internal channels
  // ------------------------------------------------------------------
  // arbiter to header builder and first stage
  tx_req_t    granted_req;
  logic       granted_req_valid;
  logic       granted_req_ready;
  byte_beat_t payload;
  logic       payload_valid;
  logic       payload_ready;

  // header builder to the stages
  udp_hdr_t   udp_hdr;
  logic       udp_hdr_en;
  logic       udp_hdr_valid;
  logic       udp_hdr_ready;
  ipv4_hdr_t  ip_hdr;
  logic       ip_hdr_valid;
  logic       ip_hdr_ready;
  eth_hdr_t   eth_hdr;
  logic       eth_hdr_valid;
  logic       eth_hdr_ready;

  // udp stage to ip stage, ip stage to ethernet stage
  byte_beat_t udp_frame;
  logic       udp_frame_valid;
  logic       udp_frame_ready;
  byte_beat_t ip_frame;
  logic       ip_frame_valid;
  logic       ip_frame_ready;

  tx_arbiter arbiter (
    .tx_clock           (tx_clock),
    .rst_n              (rst_n),
    .udp_req            (udp_req),
    .udp_req_valid      (udp_req_valid),
    .udp_req_ready      (udp_req_ready),
    .icmp_req           (icmp_req),
    .icmp_req_valid     (icmp_req_valid),
    .icmp_req_ready     (icmp_req_ready),
    .udp_payload        (udp_payload),
    .udp_payload_valid  (udp_payload_valid),
    .udp_payload_ready  (udp_payload_ready),
    .icmp_payload       (icmp_payload),
    .icmp_payload_valid (icmp_payload_valid),
    .icmp_payload_ready (icmp_payload_ready),
    .granted_req        (granted_req),
    .granted_req_valid  (granted_req_valid),
    .granted_req_ready  (granted_req_ready),
    .payload_out        (payload),
    .payload_out_valid  (payload_valid),
    .payload_out_ready  (payload_ready)
  );

  tx_header_calc header_calc (
    .tx_clock          (tx_clock),
    .rst_n             (rst_n),
    .station           (station),
    .granted_req       (granted_req),
    .granted_req_valid (granted_req_valid),
    .granted_req_ready (granted_req_ready),
    .udp_hdr           (udp_hdr),
    .udp_hdr_en        (udp_hdr_en),
    .udp_hdr_valid     (udp_hdr_valid),
    .udp_hdr_ready     (udp_hdr_ready),
    .ip_hdr            (ip_hdr),
    .ip_hdr_valid      (ip_hdr_valid),
    .ip_hdr_ready      (ip_hdr_ready),
    .eth_hdr           (eth_hdr),
    .eth_hdr_valid     (eth_hdr_valid),
    .eth_hdr_ready     (eth_hdr_ready)
  );

  // ------------------------------------------------------------------
  // prepend chain, innermost header first
  // ------------------------------------------------------------------
  // icmp frames pass this stage with enable clear
  header_prepend #(.hdr_t(udp_hdr_t)) udp_stage (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .hdr       (udp_hdr),
    .hdr_en    (udp_hdr_en),
    .hdr_valid (udp_hdr_valid),
    .hdr_ready (udp_hdr_ready),
    .in_beat   (payload),
    .in_valid  (payload_valid),
    .in_ready  (payload_ready),
    .out_beat  (udp_frame),
    .out_valid (udp_frame_valid),
    .out_ready (udp_frame_ready)
  );

  header_prepend #(.hdr_t(ipv4_hdr_t)) ip_stage (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .hdr       (ip_hdr),
    .hdr_en    (1'b1),
    .hdr_valid (ip_hdr_valid),
    .hdr_ready (ip_hdr_ready),
    .in_beat   (udp_frame),
    .in_valid  (udp_frame_valid),
    .in_ready  (udp_frame_ready),
    .out_beat  (ip_frame),
    .out_valid (ip_frame_valid),
    .out_ready (ip_frame_ready)
  );

  header_prepend #(.hdr_t(eth_hdr_t)) eth_stage (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .hdr       (eth_hdr),
    .hdr_en    (1'b1),
    .hdr_valid (eth_hdr_valid),
    .hdr_ready (eth_hdr_ready),
    .in_beat   (ip_frame),
    .in_valid  (ip_frame_valid),
    .in_ready  (ip_frame_ready),
    .out_beat  (tx_out),
    .out_valid (tx_out_valid),
    .out_ready (tx_out_ready)
  );

endmodule

`default_nettype wire

// File: hw/tx_arbiter.sv
// frame arbiter for the udp and icmp clients
// fixed priority, icmp first, one grant per whole frame
// registers the winning request and muxes its payload stream

`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
  input  wire                           tx_clock,
  input  wire                           rst_n,
  input  wire net_frame_pkg::tx_req_t   udp_req,
  input  wire                           udp_req_valid,
  output logic                          udp_req_ready,
  input  wire net_frame_pkg::tx_req_t   icmp_req,
  input  wire                           icmp_req_valid,
  output logic                          icmp_req_ready,
  input  wire net_frame_pkg::byte_beat_t udp_payload,
  input  wire                           udp_payload_valid,
  output logic                          udp_payload_ready,
  input  wire net_frame_pkg::byte_beat_t icmp_payload,
  input  wire                           icmp_payload_valid,
  output logic                          icmp_payload_ready,
  output net_frame_pkg::tx_req_t        granted_req,
  output logic                          granted_req_valid,
  input  wire                           granted_req_ready,
  output net_frame_pkg::byte_beat_t     payload_out,
  output logic                          payload_out_valid,
  input  wire                           payload_out_ready
);
  import net_frame_pkg::*;

  // grant held from request accept until last payload byte
  logic    grant;
  proto_e  sel;
  logic    take_icmp;
  logic    take_udp;
  logic    last_out;
  tx_req_t win_req;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  // icmp wins a tie, udp waits while icmp is pending
  assign icmp_req_ready = !grant;
  assign udp_req_ready  = !grant && !icmp_req_valid;
  assign take_icmp      = icmp_req_valid && icmp_req_ready;
  assign take_udp       = udp_req_valid && udp_req_ready;

  // protocol follows the client, not what it claims
  always_comb begin
    win_req       = take_icmp ? icmp_req : udp_req;
    win_req.proto = take_icmp ? PROTO_ICMP : PROTO_UDP;
  end

  // ------------------------------------------------------------------
  // payload routing
  // ------------------------------------------------------------------
  assign payload_out        = (sel == PROTO_ICMP) ? icmp_payload : udp_payload;
  assign payload_out_valid  = grant && ((sel == PROTO_ICMP) ? icmp_payload_valid
                                                             : udp_payload_valid);
  // ready goes back only to the granted client
  assign icmp_payload_ready = grant && (sel == PROTO_ICMP) && payload_out_ready;
  assign udp_payload_ready  = grant && (sel == PROTO_UDP) && payload_out_ready;
  assign last_out = payload_out_valid && payload_out_ready && payload_out.last;

  // grant and request valid
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      grant             <= 1'b0;
      sel               <= PROTO_UDP;
      granted_req_valid <= 1'b0;
    end else begin
      if (take_icmp || take_udp) begin
        grant             <= 1'b1;
        sel               <= win_req.proto;
        granted_req_valid <= 1'b1;
      end else begin
        // frame done, free for the next client
        if (last_out) begin
          grant <= 1'b0;
        end
        if (granted_req_ready) begin
          granted_req_valid <= 1'b0;
        end
      end
    end
  end

  // request contents
  always_ff @(posedge tx_clock) begin
    if (take_icmp || take_udp) begin
      granted_req <= win_req;
    end
  end

endmodule

`default_nettype wire

// File: hw/tx_header_calc.sv
// header builder for the granted request
// udp, ipv4 (with checksum and ident counter) and ethernet headers
// each held in its own register until its stage takes it

`timescale 1ns/1ps
`default_nettype none
`include "net_settings.svh"

module tx_header_calc (
  input  wire                          tx_clock,
  input  wire                          rst_n,
  input  wire net_addr_pkg::station_t  station,
  input  wire net_frame_pkg::tx_req_t  granted_req,
  input  wire                          granted_req_valid,
  output logic                         granted_req_ready,
  output net_frame_pkg::udp_hdr_t      udp_hdr,
  output logic                         udp_hdr_en,
  output logic                         udp_hdr_valid,
  input  wire                          udp_hdr_ready,
  output net_frame_pkg::ipv4_hdr_t     ip_hdr,
  output logic                         ip_hdr_valid,
  input  wire                          ip_hdr_ready,
  output net_frame_pkg::eth_hdr_t      eth_hdr,
  output logic                         eth_hdr_valid,
  input  wire                          eth_hdr_ready
);
  import net_frame_pkg::*;

  logic [15:0] ident;
  logic        take;
  logic        is_udp;
  udp_hdr_t    udp_next;
  ipv4_hdr_t   ip_next;
  eth_hdr_t    eth_next;

  // ones' complement of the folded ones' complement sum
  // over the ten header words, checksum field zero
  function automatic logic [15:0] ip_checksum(input ipv4_hdr_t h);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = sum + 32'(h[159 - 16 * i -: 16]);
    end
    // two folds catch the carry out of the first
    sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    return ~sum[15:0];
  endfunction

  // new frame only when all three headers have been taken
  assign granted_req_ready = !udp_hdr_valid && !ip_hdr_valid && !eth_hdr_valid;
  assign take   = granted_req_valid && granted_req_ready;
  assign is_udp = (granted_req.proto == PROTO_UDP);

  // ------------------------------------------------------------------
  // next headers from the request
  // ------------------------------------------------------------------
  always_comb begin
    udp_next.src_port = `NET_LOCAL_UDP_PORT;
    udp_next.dst_port = granted_req.dst.port;
    udp_next.length   = granted_req.payload_len + 16'd8;
    // zero means no udp checksum
    udp_next.checksum = 16'h0000;

    ip_next.ver_ihl    = `NET_IP_VER_IHL;
    ip_next.tos        = 8'h00;
    // icmp payload is already the full message
    ip_next.total_len  = granted_req.payload_len + (is_udp ? 16'd28 : 16'd20);
    ip_next.ident      = ident;
    ip_next.flags_frag = 16'h0000;
    ip_next.ttl        = `NET_IP_TTL;
    ip_next.proto      = is_udp ? `NET_IP_PROTO_UDP : `NET_IP_PROTO_ICMP;
    ip_next.checksum   = 16'h0000;
    ip_next.src_ip     = station.ip;
    ip_next.dst_ip     = granted_req.dst.ip;
    ip_next.checksum   = ip_checksum(ip_next);

    eth_next.dst_mac   = granted_req.dst.mac;
    eth_next.src_mac   = station.mac;
    eth_next.ethertype = `NET_ETHERTYPE_IPV4;
  end

  // ------------------------------------------------------------------
  // valid flags and ident counter
  // ------------------------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      udp_hdr_valid <= 1'b0;
      ip_hdr_valid  <= 1'b0;
      eth_hdr_valid <= 1'b0;
      ident         <= 16'h0000;
    end else if (take) begin
      udp_hdr_valid <= 1'b1;
      ip_hdr_valid  <= 1'b1;
      eth_hdr_valid <= 1'b1;
      ident         <= ident + 16'd1;
    end else begin
      // each stage drains its own header
      if (udp_hdr_ready) begin
        udp_hdr_valid <= 1'b0;
      end
      if (ip_hdr_ready) begin
        ip_hdr_valid <= 1'b0;
      end
      if (eth_hdr_ready) begin
        eth_hdr_valid <= 1'b0;
      end
    end
  end

  // header contents
  always_ff @(posedge tx_clock) begin
    if (take) begin
      udp_hdr    <= udp_next;
      udp_hdr_en <= is_udp;
      ip_hdr     <= ip_next;
      eth_hdr    <= eth_next;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the transmit framing testbench with verilator and runs it
# the run counts as passed only if the log holds the pass message

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_net_tx \
  -f filelist.f \
  --Mdir "$BUILD_DIR" \
  -o tb_net_tx
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_net_tx" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG_FILE"
  exit 1
fi

// File: tests/tb_net_tx.sv
// testbench for the transmit framing top level
// table of udp and icmp frames, byte-exact frame model,
// random back-pressure on tx_out and a cycle timeout

`timescale 1ns/1ps
`default_nettype none

module tb_net_tx;
  import net_addr_pkg::*;
  import net_frame_pkg::*;

  localparam int NUM     = 8;
  localparam int MAX_LEN = 64;

  // table row with client, payload size, destination, data seed, stall level and pairing
  typedef struct packed {
    proto_e     proto;
    logic [15:0] len;
    endpoint_t  dst;
    logic [7:0] pseed;
    logic [1:0] stall;
    logic       with_next;
  } frame_entry_t;

  localparam station_t  STATION = '{mac: 48'h02_12_34_56_78_9a, ip: 32'hc0a8_0001};
  localparam endpoint_t EP_A = '{mac: 48'h02_aa_00_00_00_01, ip: 32'hc0a8_0064, port: 16'd5000};
  localparam endpoint_t EP_B = '{mac: 48'h0c_bb_11_22_33_44, ip: 32'h0a00_0a05, port: 16'd53};
  localparam endpoint_t EP_C = '{mac: 48'hff_ff_ff_ff_ff_ff, ip: 32'hc0a8_00ff, port: 16'd9};

  // ------------------------------------------------------------------
  // dut signals
  // ------------------------------------------------------------------
  logic       tx_clock = 1'b0;
  logic       rst_n;
  station_t   station;
  tx_req_t    udp_req;
  logic       udp_req_valid;
  logic       udp_req_ready;
  tx_req_t    icmp_req;
  logic       icmp_req_valid;
  logic       icmp_req_ready;
  byte_beat_t udp_payload;
  logic       udp_payload_valid;
  logic       udp_payload_ready;
  byte_beat_t icmp_payload;
  logic       icmp_payload_valid;
  logic       icmp_payload_ready;
  byte_beat_t tx_out;
  logic       tx_out_valid;
  logic       tx_out_ready;

  // table, payloads and expected output
  frame_entry_t tbl [NUM];
  string        names [NUM];
  int           n_entries = 0;
  logic [7:0]   pay [NUM][MAX_LEN];
  // frame index in output order
  int           order [NUM];
  byte_beat_t   exp_q [$];
  byte_beat_t   want;
  integer       seed = 32'h121d4782;
  int           frames_out = 0;
  int           byte_idx = 0;
  int           cycles = 0;
  int           limit = 0;

  net_tx_top dut0 (
    .tx_clock           (tx_clock),
    .rst_n              (rst_n),
    .station            (station),
    .udp_req            (udp_req),
    .udp_req_valid      (udp_req_valid),
    .udp_req_ready      (udp_req_ready),
    .icmp_req           (icmp_req),
    .icmp_req_valid     (icmp_req_valid),
    .icmp_req_ready     (icmp_req_ready),
    .udp_payload        (udp_payload),
    .udp_payload_valid  (udp_payload_valid),
    .udp_payload_ready  (udp_payload_ready),
    .icmp_payload       (icmp_payload),
    .icmp_payload_valid (icmp_payload_valid),
    .icmp_payload_ready (icmp_payload_ready),
    .tx_out             (tx_out),
    .tx_out_valid       (tx_out_valid),
    .tx_out_ready       (tx_out_ready)
  );

  // 100 ns period
  always #50 tx_clock = ~tx_clock;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_entry(input string name, input proto_e proto, input int len,
                           input endpoint_t dst, input logic [7:0] pseed,
                           input logic [1:0] stall, input logic with_next);
    tbl[n_entries] = '{proto, 16'(len), dst, pseed, stall, with_next};
    names[n_entries] = name;
    n_entries++;
  endtask

  // ------------------------------------------------------------------
  // frame model
  // ------------------------------------------------------------------
  task automatic push_byte(input logic [7:0] d, input logic last);
    byte_beat_t b;
    b.data = d;
    b.last = last;
    exp_q.push_back(b);
  endtask

  // ones' complement sum of the ten words, folded, then inverted
  function automatic logic [15:0] header_checksum(input logic [7:0] hb [20]);
    int sum;
    sum = 0;
    for (int k = 0; k < 10; k++) begin
      sum = sum + int'({hb[2 * k], hb[2 * k + 1]});
    end
    while ((sum >> 16) != 0) begin
      sum = (sum & 32'hffff) + (sum >> 16);
    end
    return ~sum[15:0];
  endfunction

  task automatic build_frame(input int idx, input logic [15:0] ident);
    frame_entry_t e;
    logic [7:0]   hb [20];
    logic [15:0]  tot;
    logic [15:0]  csum;
    logic         udp;
    e   = tbl[idx];
    udp = (e.proto == PROTO_UDP);
    // ip total length covers the udp header only for udp
    tot = e.len + (udp ? 16'd28 : 16'd20);
    for (int k = 0; k < 6; k++) begin
      push_byte(e.dst.mac[47 - 8 * k -: 8], 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      push_byte(STATION.mac[47 - 8 * k -: 8], 1'b0);
    end
    push_byte(8'h08, 1'b0);
    push_byte(8'h00, 1'b0);
    hb[0]  = 8'h45;
    hb[1]  = 8'h00;
    hb[2]  = tot[15:8];
    hb[3]  = tot[7:0];
    hb[4]  = ident[15:8];
    hb[5]  = ident[7:0];
    hb[6]  = 8'h00;
    hb[7]  = 8'h00;
    hb[8]  = 8'd128;
    hb[9]  = udp ? 8'd17 : 8'd1;
    hb[10] = 8'h00;
    hb[11] = 8'h00;
    for (int k = 0; k < 4; k++) begin
      hb[12 + k] = STATION.ip[31 - 8 * k -: 8];
      hb[16 + k] = e.dst.ip[31 - 8 * k -: 8];
    end
    csum   = header_checksum(hb);
    hb[10] = csum[15:8];
    hb[11] = csum[7:0];
    for (int k = 0; k < 20; k++) begin
      push_byte(hb[k], 1'b0);
    end
    if (udp) begin
      // source port 1024, zero checksum
      push_byte(8'h04, 1'b0);
      push_byte(8'h00, 1'b0);
      push_byte(e.dst.port[15:8], 1'b0);
      push_byte(e.dst.port[7:0], 1'b0);
      push_byte(8'((e.len + 16'd8) >> 8), 1'b0);
      push_byte(8'(e.len + 16'd8), 1'b0);
      push_byte(8'h00, 1'b0);
      push_byte(8'h00, 1'b0);
    end
    for (int k = 0; k < int'(e.len); k++) begin
      push_byte(pay[idx][k], k == int'(e.len) - 1);
    end
  endtask

  // icmp goes first when a udp entry is paired with an icmp one
  task automatic make_order();
    int i;
    int n;
    i = 0;
    n = 0;
    while (i < NUM) begin
      if (tbl[i].with_next && tbl[i].proto == PROTO_UDP && tbl[i + 1].proto == PROTO_ICMP) begin
        order[n]     = i + 1;
        order[n + 1] = i;
        n += 2;
        i += 2;
      end else begin
        order[n] = i;
        n++;
        i++;
      end
    end
  endtask

  // ------------------------------------------------------------------
  // client drivers
  // ------------------------------------------------------------------
  task automatic drive_request(input proto_e proto, input tx_req_t req, input logic valid);
    if (proto == PROTO_ICMP) begin
      icmp_req       = req;
      icmp_req_valid = valid;
    end else begin
      udp_req       = req;
      udp_req_valid = valid;
    end
  endtask

  task automatic drive_beat(input proto_e proto, input byte_beat_t beat, input logic valid);
    if (proto == PROTO_ICMP) begin
      icmp_payload       = beat;
      icmp_payload_valid = valid;
    end else begin
      udp_payload       = beat;
      udp_payload_valid = valid;
    end
  endtask

  // ready sampled mid-cycle and the transfer lands on the next edge
  task automatic wait_accept(input proto_e proto, input logic is_payload);
    logic ok;
    ok = 1'b0;
    while (!ok) begin
      @(negedge tx_clock);
      if (is_payload) begin
        ok = (proto == PROTO_ICMP) ? icmp_payload_ready : udp_payload_ready;
      end else begin
        ok = (proto == PROTO_ICMP) ? icmp_req_ready : udp_req_ready;
      end
      @(posedge tx_clock);
    end
  endtask

  task automatic send_frame(input int idx);
    frame_entry_t e;
    tx_req_t      req;
    byte_beat_t   beat;
    e               = tbl[idx];
    req.proto       = e.proto;
    req.payload_len = e.len;
    req.dst         = e.dst;
    @(posedge tx_clock);
    #1;
    drive_request(e.proto, req, 1'b1);
    wait_accept(e.proto, 1'b0);
    #1;
    drive_request(e.proto, req, 1'b0);
    for (int k = 0; k < int'(e.len); k++) begin
      beat.data = pay[idx][k];
      beat.last = (k == int'(e.len) - 1);
      drive_beat(e.proto, beat, 1'b1);
      wait_accept(e.proto, 1'b1);
      #1;
    end
    beat = '0;
    drive_beat(e.proto, beat, 1'b0);
  endtask

  // ------------------------------------------------------------------
  // output side with back-pressure, checker and timeout
  // ------------------------------------------------------------------
  // stall level of the frame now leaving sets how often ready drops
  initial begin
    int lvl;
    tx_out_ready = 1'b0;
    forever begin
      @(posedge tx_clock);
      #1;
      lvl = (frames_out < NUM) ? int'(tbl[order[frames_out]].stall) : 0;
      tx_out_ready = (lvl == 0) || (($random(seed) & 3) >= lvl);
    end
  end

  always @(negedge tx_clock) begin
    if (tx_out_valid && tx_out_ready) begin
      if (exp_q.size() == 0) begin
        $display("tx_out delivered a byte after every expected frame was complete");
        $display("Test FAILED");
        $fatal(1);
      end else begin
        want = exp_q.pop_front();
        compare_value($sformatf("%s byte %0d data", names[order[frames_out]], byte_idx),
                      32'(want.data), 32'(tx_out.data));
        compare_value($sformatf("%s byte %0d last", names[order[frames_out]], byte_idx),
                      32'(want.last), 32'(tx_out.last));
        if (want.last) begin
          frames_out++;
          byte_idx = 0;
        end else begin
          byte_idx++;
        end
      end
    end
  end

  always @(posedge tx_clock) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the frames did not all leave tx_out within %0d cycles", limit);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int i;
    int total;
    rst_n              = 1'b0;
    station            = STATION;
    udp_req            = '0;
    udp_req_valid      = 1'b0;
    icmp_req           = '0;
    icmp_req_valid     = 1'b0;
    udp_payload        = '0;
    udp_payload_valid  = 1'b0;
    icmp_payload       = '0;
    icmp_payload_valid = 1'b0;

    // name, client, payload bytes, destination, seed, stall level, paired
    add_entry("udp_basic", PROTO_UDP, 18, EP_A, 8'h00, 2'd0, 1'b0);
    add_entry("icmp_echo", PROTO_ICMP, 24, EP_B, 8'h5a, 2'd0, 1'b0);
    add_entry("udp_one_byte", PROTO_UDP, 1, EP_C, 8'h11, 2'd0, 1'b0);
    add_entry("udp_pair", PROTO_UDP, 20, EP_A, 8'h3c, 2'd0, 1'b1);
    add_entry("icmp_pair", PROTO_ICMP, 12, EP_B, 8'hc3, 2'd0, 1'b0);
    add_entry("udp_stall", PROTO_UDP, 40, EP_C, 8'h81, 2'd2, 1'b0);
    add_entry("icmp_stall", PROTO_ICMP, 33, EP_A, 8'h24, 2'd1, 1'b0);
    add_entry("udp_long", PROTO_UDP, 64, EP_B, 8'hf0, 2'd1, 1'b0);

    for (int n = 0; n < NUM; n++) begin
      for (int k = 0; k < int'(tbl[n].len); k++) begin
        pay[n][k] = 8'($random(seed)) ^ tbl[n].pseed;
      end
    end
    make_order();
    // ident counts in the order frames are granted
    total = 0;
    for (int n = 0; n < NUM; n++) begin
      build_frame(order[n], 16'(n));
      total += 34 + int'(tbl[n].len) + ((tbl[n].proto == PROTO_UDP) ? 8 : 0);
    end
    limit = 2 * total + 200;

    repeat (10) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;

    // idle with nothing out and both clients free to ask
    repeat (6) begin
      @(negedge tx_clock);
      compare_value("idle tx_out_valid", 32'd0, 32'(tx_out_valid));
    end
    compare_value("idle udp_req_ready", 32'd1, 32'(udp_req_ready));
    compare_value("idle icmp_req_ready", 32'd1, 32'(icmp_req_ready));

    i = 0;
    while (i < NUM) begin
      if (tbl[i].with_next) begin
        // both requests raised on the same cycle
        fork
          send_frame(i);
          send_frame(i + 1);
        join
        i += 2;
      end else begin
        send_frame(i);
        i++;
      end
    end

    while (frames_out < NUM) begin
      @(posedge tx_clock);
    end
    repeat (4) @(negedge tx_clock);
    compare_value("drain tx_out_valid", 32'd0, 32'(tx_out_valid));
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
